//--- aes_apb_top.sv
`timescale 1ns/100ps

module aes_apb_top
(
	input  logic                   PCLK,
	input  logic                   PRESETn,
	input  logic [3:0]             PADDR,
	input  logic [12:0]            PWDATA,
	input  logic                   PWRITE,
	input  logic                   PENABLE,
	input  logic                   PSEL,
	output logic [31:0]            PRDATA,
	output aes_bus_pkg::core_req_t core_req,
	input  aes_bus_pkg::core_rsp_t core_rsp,
	output logic                   int_ccf,
	output logic                   int_err,
	output logic                   dma_req_wr,
	output logic                   dma_req_rd,
	output logic                   disable_core
);

	import aes_cfg_pkg::*;
	import aes_bus_pkg::*;

	apb_req_t     apb;
	logic [31:0]  wdata;
	logic [31:0]  key_bus;
	logic [31:0]  iv_bus;
	logic [31:0]  col_bus;
	logic [3:0]   key_en;
	logic [1:0]   key_sel;
	logic [3:0]   iv_en;
	logic [3:0]   iv_sel;
	logic [1:0]   col_addr;
	logic         col_wr_en;
	logic         col_rd_en;
	logic         start_core;
	logic         first_block;
	op_mode_t     mode;
	chain_mode_t  chmod;
	data_type_t   data_type;
	logic [127:0] key;
	logic [127:0] iv;
	logic [127:0] block;

	assign apb   = '{paddr: PADDR, pwdata: PWDATA, pwrite: PWRITE,
		penable: PENABLE, psel: PSEL};
	assign wdata = {19'd0, PWDATA};

	aes_host_if host0
	(
		.PCLK         (PCLK),
		.PRESETn      (PRESETn),
		.apb          (apb),
		.PRDATA       (PRDATA),
		.key_bus      (key_bus),
		.iv_bus       (iv_bus),
		.col_bus      (col_bus),
		.ccf_set      (core_rsp.done),
		.key_en       (key_en),
		.key_sel      (key_sel),
		.iv_en        (iv_en),
		.iv_sel       (iv_sel),
		.col_addr     (col_addr),
		.col_wr_en    (col_wr_en),
		.col_rd_en    (col_rd_en),
		.start_core   (start_core),
		.first_block  (first_block),
		.mode         (mode),
		.chmod        (chmod),
		.data_type    (data_type),
		.int_ccf      (int_ccf),
		.int_err      (int_err),
		.dma_req_wr   (dma_req_wr),
		.dma_req_rd   (dma_req_rd),
		.disable_core (disable_core)
	);

	aes_key_bank key0
	(
		.PCLK    (PCLK),
		.PRESETn (PRESETn),
		.wdata   (wdata),
		.key_en  (key_en),
		.key_sel (key_sel),
		.key_bus (key_bus),
		.key     (key)
	);

	aes_iv_bank iv0
	(
		.PCLK    (PCLK),
		.PRESETn (PRESETn),
		.wdata   (wdata),
		.iv_en   (iv_en),
		.iv_sel  (iv_sel),
		.iv_bus  (iv_bus),
		.iv      (iv)
	);

	aes_col_buffer buf0
	(
		.PCLK      (PCLK),
		.PRESETn   (PRESETn),
		.wdata     (wdata),
		.col_addr  (col_addr),
		.col_wr_en (col_wr_en),
		.col_rd_en (col_rd_en),
		.rsp       (core_rsp),
		.col_bus   (col_bus),
		.block     (block)
	);

	// Engine request
	assign core_req = '{start: start_core, first_block: first_block, mode: mode,
		chmod: chmod, data_type: data_type, key: key, iv: iv, data: block};

endmodule

//--- aes_bus_pkg.sv
package aes_bus_pkg;

	// APB request as seen by the host interface
	typedef struct packed
	{
		logic [3:0]  paddr;
		logic [12:0] pwdata;
		logic        pwrite;
		logic        penable;
		logic        psel;
	} apb_req_t;

	// Request to the cipher engine
	typedef struct packed
	{
		logic                     start;
		logic                     first_block;
		aes_cfg_pkg::op_mode_t    mode;
		aes_cfg_pkg::chain_mode_t chmod;
		aes_cfg_pkg::data_type_t  data_type;
		logic [127:0]             key;
		logic [127:0]             iv;
		logic [127:0]             data;
	} core_req_t;

	// Engine completion with result block
	typedef struct packed
	{
		logic         done;
		logic [127:0] data;
	} core_rsp_t;

endpackage

//--- aes_cfg_pkg.sv
package aes_cfg_pkg;

	// Operation mode field of CR
	typedef enum logic [1:0]
	{
		OP_ENC       = 2'b00,
		OP_KEY_DERIV = 2'b01,
		OP_DEC       = 2'b10,
		OP_DEC_DERIV = 2'b11
	} op_mode_t;

	// Chaining mode field of CR
	typedef enum logic [1:0]
	{
		CH_ECB = 2'b00,
		CH_CBC = 2'b01,
		CH_CTR = 2'b10
	} chain_mode_t;

	// Byte swap selection, engine side only
	typedef logic [1:0] data_type_t;

	// Stored configuration, also the CR readback layout
	typedef struct packed
	{
		logic        dma_out_en;
		logic        dma_in_en;
		logic        err_ie;
		logic        ccf_ie;
		logic [1:0]  rsvd;
		chain_mode_t chmod;
		op_mode_t    mode;
		data_type_t  data_type;
		logic        enable;
	} cr_cfg_t;

	// Flag clear bits sharing the same write word
	typedef struct packed
	{
		logic [3:0] rsvd_hi;
		logic       errc;
		logic       ccfc;
		logic [6:0] rsvd_lo;
	} cr_cmd_t;

	typedef union packed
	{
		cr_cfg_t cfg;
		cr_cmd_t cmd;
	} cr_wdata_u;

endpackage

//--- aes_col_buffer.sv
`timescale 1ns/100ps
`include "aes_consts.svh"

module aes_col_buffer
(
	input  logic                  PCLK,
	input  logic                  PRESETn,
	input  logic [31:0]           wdata,
	input  logic [1:0]            col_addr,
	input  logic                  col_wr_en,
	input  logic                  col_rd_en,
	input  aes_bus_pkg::core_rsp_t rsp,
	output logic [31:0]           col_bus,
	output logic [127:0]          block
);

	// Column 0 sits in the most significant word
	logic [0:`AES_NWORDS-1][31:0] col_q;

	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			col_q <= '0;
		else if (rsp.done)
			// Engine result replaces the whole block
			col_q <= rsp.data;
		else if (col_wr_en)
			col_q[col_addr] <= wdata;
	end

	assign col_bus = col_rd_en ? col_q[col_addr] : 32'd0;
	assign block   = col_q;

endmodule

//--- aes_consts.svh
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// ========================================
// Register word addresses
// ========================================
`define AES_CR     4'd0
`define AES_SR     4'd1
`define AES_DINR   4'd2
`define AES_DOUTR  4'd3
// Key words at 4..7, IV words at 8..11
`define AES_KEYR0  4'd4
`define AES_IVR0   4'd8

// Reset values
`define AES_CR_RESET  13'd0
`define AES_SR_RESET  3'd0

// Words per 128-bit block
`define AES_NWORDS  4

`endif

//--- aes_golden.txt
# columns: W addr data | R addr expected | S first_block data0-3 key0-3 iv0-3
# columns: D wait result0-3 | P dma_wr dma_rd int_err int_ccf disable_core | T name
W 0 0634
R 0 0634
W 0 0058
R 0 0050
W 0 0051
W 0 0623
R 0 0051
W 0 0000
R 0 0050
T config
W 4 0a11
W 5 0b22
W 6 0c33
W 7 0d44
W 8 1e55
W 9 1f66
W a 0177
W b 0288
R 4 0a11
R 7 0d44
R 8 1e55
R b 0288
W 0 0001
R 4 0000
R 9 0000
W 0 0000
T keyiv
W 0 0201
W 2 0101
W 2 0202
W 2 0303
W 2 0404
S 1 0101 0202 0303 0404 0a11 0b22 0c33 0d44 1e55 1f66 0177 0288
D 3 1aaa 1bbb 1ccc 1ddd
R 1 0001
R 3 1aaa
R 3 1bbb
R 3 1ccc
R 3 1ddd
W 2 0505
W 2 0606
W 2 0707
W 2 0808
S 0 0505 0606 0707 0808 0a11 0b22 0c33 0d44 1e55 1f66 0177 0288
D 2 0aaa 0bbb 0ccc 0ddd
P 0 0 0 2 0
W 0 0080
R 1 0000
T block
W 0 0401
R 3 0000
W 2 0111
W 2 0222
W 2 0333
W 2 0444
S 1 0111 0222 0333 0444 0a11 0b22 0c33 0d44 1e55 1f66 0177 0288
W 2 0999
D 2 0e01 0e02 0e03 0e04
R 1 0007
P 0 0 2 0 0
W 0 0180
R 1 0000
T errors
W 0 0009
S 1 0e01 0e02 0e03 0e04 0a11 0b22 0c33 0d44 1e55 1f66 0177 0288
D 3 0f01 0f02 0f03 0f04
R 0 0008
P 0 0 0 0 1
W 0 0080
T keyderiv
W 0 1801
W 2 0121
W 2 0232
W 2 0343
W 2 0454
S 1 0121 0232 0343 0454 0a11 0b22 0c33 0d44 1e55 1f66 0177 0288
P 4 0 0 0 0
D 1 0565 0676 0787 0898
R 3 0565
R 3 0676
R 3 0787
R 3 0898
P 1 4 0 0 0
W 0 0000
T dma

//--- aes_host_if.sv
`timescale 1ns/100ps
`include "aes_consts.svh"

module aes_host_if
(
	input  logic                     PCLK,
	input  logic                     PRESETn,
	input  aes_bus_pkg::apb_req_t    apb,
	output logic [31:0]              PRDATA,
	input  logic [31:0]              key_bus,
	input  logic [31:0]              iv_bus,
	input  logic [31:0]              col_bus,
	input  logic                     ccf_set,
	output logic [3:0]               key_en,
	output logic [1:0]               key_sel,
	output logic [3:0]               iv_en,
	output logic [3:0]               iv_sel,
	output logic [1:0]               col_addr,
	output logic                     col_wr_en,
	output logic                     col_rd_en,
	output logic                     start_core,
	output logic                     first_block,
	output aes_cfg_pkg::op_mode_t    mode,
	output aes_cfg_pkg::chain_mode_t chmod,
	output aes_cfg_pkg::data_type_t  data_type,
	output logic                     int_ccf,
	output logic                     int_err,
	output logic                     dma_req_wr,
	output logic                     dma_req_rd,
	output logic                     disable_core
);

	import aes_cfg_pkg::*;

	typedef enum logic [2:0]
	{
		IDLE,
		INPUT,
		START,
		WAIT,
		OUTPUT
	} state_t;

	state_t      state;
	state_t      next_state;
	cr_cfg_t     cr_q;
	cr_wdata_u   cr_in;
	logic        wr_err;
	logic        rd_err;
	logic        ccf;
	logic [1:0]  cnt;
	logic        cnt_en;
	logic        dma_q;
	logic        write_en;
	logic        read_en;
	logic        cr_wr;
	logic        access_ok;
	logic        key_deriv;
	logic        key_hit;
	logic        iv_hit;
	logic        din_wr;
	logic        dout_rd;
	logic        wr_err_en;
	logic        rd_err_en;
	logic        enable_clear;
	logic [31:0] rd_mux;

	// ========================================
	// APB decode
	// ========================================
	assign write_en = apb.psel & apb.penable & apb.pwrite;
	assign read_en  = apb.psel & ~apb.pwrite;
	assign cr_in    = apb.pwdata;
	assign cr_wr    = write_en && (apb.paddr == `AES_CR);
	assign key_hit  = (apb.paddr[3:2] == `AES_KEYR0 >> 2);
	assign iv_hit   = (apb.paddr[3:2] == `AES_IVR0 >> 2);
	assign din_wr   = write_en && (apb.paddr == `AES_DINR);
	// Access phase only, so a read counts once
	assign dout_rd  = read_en && apb.penable && (apb.paddr == `AES_DOUTR);

	// Config fields are only open in IDLE
	assign access_ok = (state == IDLE);
	assign key_deriv = (cr_q.mode == OP_KEY_DERIV);

	// Control register
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			cr_q <= `AES_CR_RESET;
		else
		begin
			if (enable_clear)
				cr_q.enable <= 1'b0;
			else if (cr_wr)
				cr_q.enable <= cr_in.cfg.enable;
			if (cr_wr && access_ok)
			begin
				cr_q.dma_out_en <= cr_in.cfg.dma_out_en;
				cr_q.dma_in_en  <= cr_in.cfg.dma_in_en;
				cr_q.err_ie     <= cr_in.cfg.err_ie;
				cr_q.ccf_ie     <= cr_in.cfg.ccf_ie;
				cr_q.chmod      <= cr_in.cfg.chmod;
				cr_q.data_type  <= cr_in.cfg.data_type;
				// No derivation step in CTR, plain decryption instead
				if (cr_in.cfg.mode == OP_DEC_DERIV && cr_in.cfg.chmod == CH_CTR)
					cr_q.mode <= OP_DEC;
				else
					cr_q.mode <= cr_in.cfg.mode;
			end
		end
	end

	// Status flags, set wins over clear
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			{wr_err, rd_err, ccf} <= `AES_SR_RESET;
		else
		begin
			if (wr_err_en)
				wr_err <= 1'b1;
			else if (cr_wr && cr_in.cmd.errc)
				wr_err <= 1'b0;
			if (rd_err_en)
				rd_err <= 1'b1;
			else if (cr_wr && cr_in.cmd.errc)
				rd_err <= 1'b0;
			if (ccf_set)
				ccf <= 1'b1;
			else if (cr_wr && cr_in.cmd.ccfc)
				ccf <= 1'b0;
		end
	end

	assign int_ccf = cr_q.ccf_ie & ccf_set;
	assign int_err = cr_q.err_ie & (wr_err_en | rd_err_en);

	// ========================================
	// Block sequencer
	// ========================================
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			state <= IDLE;
		else if (!cr_q.enable)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (cr_q.enable)
					next_state = key_deriv ? START : INPUT;
			INPUT:
				if (din_wr && cnt == 2'b11)
					next_state = START;
			START:
				next_state = WAIT;
			WAIT:
				if (ccf_set)
					next_state = key_deriv ? IDLE : OUTPUT;
			OUTPUT:
				if (dout_rd && cnt == 2'b11)
					next_state = INPUT;
			default:
				next_state = IDLE;
		endcase
	end

	assign start_core   = (state == START);
	assign enable_clear = (state == WAIT) && ccf_set && key_deriv;
	assign disable_core = ~cr_q.enable;

	// Counter wraps 3 -> 0 on entry to INPUT and OUTPUT
	assign cnt_en = ((state == IDLE) && cr_q.enable && !key_deriv)
		| ((state == INPUT) && din_wr)
		| ((state == WAIT) && ccf_set && !key_deriv)
		| ((state == OUTPUT) && dout_rd);

	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			cnt <= 2'b11;
		else if (!cr_q.enable || state == START)
			cnt <= 2'b11;
		else if (cnt_en)
			cnt <= cnt + 2'd1;
	end

	// IV only used on the first block after IDLE
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			first_block <= 1'b1;
		else if (state == IDLE)
			first_block <= 1'b1;
		else if (state == OUTPUT)
			first_block <= 1'b0;
	end

	assign mode      = cr_q.mode;
	assign chmod     = cr_q.chmod;
	assign data_type = cr_q.data_type;

	// Bank and buffer strobes
	assign key_en    = (4'b1000 >> apb.paddr[1:0]) & {4{key_hit & access_ok & write_en}};
	assign key_sel   = ~apb.paddr[1:0];
	assign iv_sel    = (4'b1000 >> apb.paddr[1:0]) & {4{iv_hit}};
	assign iv_en     = iv_sel & {4{access_ok & write_en}};
	assign col_addr  = cnt;
	assign col_wr_en = din_wr && (state == INPUT);
	assign col_rd_en = read_en && (apb.paddr == `AES_DOUTR) && (state == OUTPUT);

	// Protocol violations
	assign wr_err_en = din_wr && !(state == INPUT || state == IDLE);
	assign rd_err_en = dout_rd && !(state == OUTPUT || state == IDLE);

	// DMA requests on each toggle of the counter low bit
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			dma_q <= 1'b0;
		else
			dma_q <= cnt[0];
	end

	assign dma_req_wr = (dma_q ^ cnt[0]) & cr_q.dma_in_en & cr_q.enable
		& (state == INPUT || state == IDLE);
	assign dma_req_rd = (dma_q ^ cnt[0]) & cr_q.dma_out_en & cr_q.enable
		& (state == OUTPUT);

	// ========================================
	// Read data
	// ========================================
	always_comb
	begin
		rd_mux = 32'd0;
		case (apb.paddr)
			`AES_CR:
				rd_mux = {19'd0, cr_q};
			`AES_SR:
				rd_mux = {29'd0, wr_err, rd_err, ccf};
			`AES_DOUTR:
				if (ccf || ccf_set)
					rd_mux = col_bus;
			default:
				// key and IV hidden while enabled
				if (key_hit && !cr_q.enable)
					rd_mux = key_bus;
				else if (iv_hit && !cr_q.enable)
					rd_mux = iv_bus;
		endcase
	end

	assign PRDATA = read_en ? rd_mux : 32'd0;

endmodule

//--- aes_iv_bank.sv
`timescale 1ns/100ps
`include "aes_consts.svh"

module aes_iv_bank
(
	input  logic         PCLK,
	input  logic         PRESETn,
	input  logic [31:0]  wdata,
	input  logic [3:0]   iv_en,
	input  logic [3:0]   iv_sel,
	output logic [31:0]  iv_bus,
	output logic [127:0] iv
);

	logic [`AES_NWORDS-1:0][31:0] iv_q;

	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			iv_q <= '0;
		else
		begin
			for (int i = 0; i < `AES_NWORDS; i++)
			begin
				if (iv_en[i])
					iv_q[i] <= wdata;
			end
		end
	end

	// One-hot select, AND-OR mux
	always_comb
	begin
		iv_bus = 32'd0;
		for (int i = 0; i < `AES_NWORDS; i++)
			iv_bus = iv_bus | (iv_q[i] & {32{iv_sel[i]}});
	end

	assign iv = iv_q;

endmodule

//--- aes_key_bank.sv
`timescale 1ns/100ps
`include "aes_consts.svh"

module aes_key_bank
(
	input  logic         PCLK,
	input  logic         PRESETn,
	input  logic [31:0]  wdata,
	input  logic [3:0]   key_en,
	input  logic [1:0]   key_sel,
	output logic [31:0]  key_bus,
	output logic [127:0] key
);

	// Word 3 is the most significant key word
	logic [`AES_NWORDS-1:0][31:0] key_q;

	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			key_q <= '0;
		else
		begin
			for (int i = 0; i < `AES_NWORDS; i++)
			begin
				if (key_en[i])
					key_q[i] <= wdata;
			end
		end
	end

	// Binary read select
	assign key_bus = key_q[key_sel];
	assign key     = key_q;

endmodule

//--- aes_tb.sv
`timescale 1ns/100ps
`include "aes_consts.svh"

module aes_tb;

	import aes_bus_pkg::*;

	logic        PCLK;
	logic        PRESETn;
	logic [3:0]  PADDR;
	logic [12:0] PWDATA;
	logic        PWRITE;
	logic        PENABLE;
	logic        PSEL;
	logic [31:0] PRDATA;
	core_req_t   core_req;
	core_rsp_t   core_rsp;
	logic        int_ccf;
	logic        int_err;
	logic        dma_req_wr;
	logic        dma_req_rd;
	logic        disable_core;

	// Fields of the current golden line
	logic [31:0] fld [0:12];
	int          n_wr = 0;
	int          n_rd = 0;
	int          n_err = 0;
	int          n_ccf = 0;
	int          cycles = 0;
	int          limit = 0;
	int          test_errs = 0;
	int          fail_total = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	// Configuration the engine should see, from CR writes made while disabled
	logic [12:0] cfg_word = 13'd0;
	logic        cfg_en = 1'b0;

	aes_apb_top dut0
	(
		.PCLK         (PCLK),
		.PRESETn      (PRESETn),
		.PADDR        (PADDR),
		.PWDATA       (PWDATA),
		.PWRITE       (PWRITE),
		.PENABLE      (PENABLE),
		.PSEL         (PSEL),
		.PRDATA       (PRDATA),
		.core_req     (core_req),
		.core_rsp     (core_rsp),
		.int_ccf      (int_ccf),
		.int_err      (int_err),
		.dma_req_wr   (dma_req_wr),
		.dma_req_rd   (dma_req_rd),
		.disable_core (disable_core)
	);

	initial
	begin
		PCLK = 1'b0;
		forever
			#5 PCLK = ~PCLK;
	end

	always @(posedge PCLK)
	begin
		cycles++;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout after %0d cycles, the DUT stopped responding", limit);
			$display("Test failures found");
			$finish;
		end
	end

	// Pulse outputs, sampled mid-cycle
	always @(negedge PCLK)
	begin
		if (dma_req_wr)
			n_wr++;
		if (dma_req_rd)
			n_rd++;
		if (int_err)
			n_err++;
		if (int_ccf)
			n_ccf++;
	end

	// ========================================
	// Checks
	// ========================================
	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp)
		else
		begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", what, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond)
		else
		begin
			$display("%s", msg);
			test_errs++;
		end
	endtask

	// ========================================
	// APB transfers
	// ========================================
	task automatic apb_write(input logic [3:0] addr, input logic [12:0] data);
		@(posedge PCLK);
		#1;
		PSEL    = 1'b1;
		PWRITE  = 1'b1;
		PENABLE = 1'b0;
		PADDR   = addr;
		PWDATA  = data;
		@(posedge PCLK);
		#1;
		PENABLE = 1'b1;
		@(posedge PCLK);
		#1;
		PSEL    = 1'b0;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		@(posedge PCLK);
		#1;
		PSEL    = 1'b1;
		PWRITE  = 1'b0;
		PENABLE = 1'b0;
		PADDR   = addr;
		@(posedge PCLK);
		#1;
		PENABLE = 1'b1;
		// Access phase data
		@(negedge PCLK);
		data = PRDATA;
		@(posedge PCLK);
		#1;
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	// Config fields only take a CR write made while disabled
	task automatic track_cr_write(input logic [3:0] addr, input logic [12:0] data);
		if (addr == `AES_CR)
		begin
			if (!cfg_en)
				cfg_word = data;
			cfg_en = data[0];
		end
	endtask

	// ========================================
	// Engine model and golden operations
	// ========================================
	task automatic expect_start();
		logic [1:0] exp_mode;
		// Decryption with derivation under CTR runs as decryption
		if (cfg_word[4:3] == 2'b11 && cfg_word[6:5] == 2'b10)
			exp_mode = 2'b10;
		else
			exp_mode = cfg_word[4:3];
		@(negedge PCLK);
		while (!core_req.start)
			@(negedge PCLK);
		check_value("core_req.first_block", core_req.first_block, fld[0]);
		check_value("core_req.data", core_req.data, {fld[1], fld[2], fld[3], fld[4]});
		check_value("core_req.key", core_req.key, {fld[5], fld[6], fld[7], fld[8]});
		check_value("core_req.iv", core_req.iv, {fld[9], fld[10], fld[11], fld[12]});
		check_value("core_req.mode", core_req.mode, exp_mode);
		check_value("core_req.chmod", core_req.chmod, cfg_word[6:5]);
		check_value("core_req.data_type", core_req.data_type, cfg_word[2:1]);
		@(negedge PCLK);
		check_true(!core_req.start, "engine start stayed high for more than one cycle");
	endtask

	task automatic engine_done();
		repeat (fld[0])
			@(posedge PCLK);
		#1;
		core_rsp.done = 1'b1;
		core_rsp.data = {fld[1], fld[2], fld[3], fld[4]};
		@(posedge PCLK);
		#1;
		core_rsp.done = 1'b0;
	endtask

	task automatic clear_counts();
		n_wr  = 0;
		n_rd  = 0;
		n_err = 0;
		n_ccf = 0;
	endtask

	task automatic check_pulses();
		// Let the last pulse of the previous transfer settle
		repeat (2)
			@(posedge PCLK);
		#1;
		check_value("dma_req_wr count", n_wr, fld[0]);
		check_value("dma_req_rd count", n_rd, fld[1]);
		check_value("int_err count", n_err, fld[2]);
		check_value("int_ccf count", n_ccf, fld[3]);
		check_value("disable_core", disable_core, fld[4]);
		clear_counts();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: FAILED with %0d errors", name, test_errs);
			tests_failed++;
		end
		fail_total += test_errs;
		test_errs = 0;
		clear_counts();
	endtask

	task automatic read_fields(input int fd, input int n);
		int code;
		for (int i = 0; i < n; i++)
		begin
			code = $fscanf(fd, "%h", fld[i]);
			if (code != 1)
			begin
				$display("golden line is missing field %0d", i);
				test_errs++;
				fld[i] = '0;
			end
		end
	endtask

	task automatic run_golden(input int fd);
		int          code;
		int          c;
		string       op;
		string       name;
		logic [31:0] rdata;
		code = $fscanf(fd, "%s", op);
		while (code == 1)
		begin
			case (op)
				"#":
				begin
					c = $fgetc(fd);
					while (c != 10 && c != -1)
						c = $fgetc(fd);
				end
				"W":
				begin
					read_fields(fd, 2);
					track_cr_write(fld[0][3:0], fld[1][12:0]);
					apb_write(fld[0][3:0], fld[1][12:0]);
				end
				"R":
				begin
					read_fields(fd, 2);
					apb_read(fld[0][3:0], rdata);
					check_value($sformatf("PRDATA[%0h]", fld[0][3:0]), rdata, fld[1]);
				end
				"S":
				begin
					read_fields(fd, 13);
					expect_start();
				end
				"D":
				begin
					read_fields(fd, 5);
					engine_done();
				end
				"P":
				begin
					read_fields(fd, 5);
					check_pulses();
				end
				"T":
				begin
					code = $fscanf(fd, "%s", name);
					end_test(name);
				end
				default:
				begin
					$display("unknown golden operation %s", op);
					test_errs++;
				end
			endcase
			code = $fscanf(fd, "%s", op);
		end
	endtask

	initial
	begin
		int fd;
		int c;
		int nlines;
		PRESETn  = 1'b0;
		PADDR    = 4'd0;
		PWDATA   = 13'd0;
		PWRITE   = 1'b0;
		PENABLE  = 1'b0;
		PSEL     = 1'b0;
		core_rsp = '0;
		nlines   = 0;
		fd = $fopen("aes_golden.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the golden file aes_golden.txt");
			fail_total++;
		end
		else
		begin
			// Run limit from the golden length
			c = $fgetc(fd);
			while (c != -1)
			begin
				if (c == 10)
					nlines++;
				c = $fgetc(fd);
			end
			$fclose(fd);
			limit = nlines * 20 + 200;
			repeat (4)
				@(posedge PCLK);
			#1;
			PRESETn = 1'b1;
			fd = $fopen("aes_golden.txt", "r");
			run_golden(fd);
			$fclose(fd);
		end
		fail_total += test_errs;
		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, fail_total);
		if (fail_total == 0 && tests_run > 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
# Build the AES APB testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module aes_tb -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vaes_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1

//--- vlog.f
+incdir+.
aes_cfg_pkg.sv
aes_bus_pkg.sv
aes_host_if.sv
aes_key_bank.sv
aes_iv_bank.sv
aes_col_buffer.sv
aes_apb_top.sv
aes_tb.sv
